/* include/accum_consts.svh */
`ifndef ACCUM_CONSTS_SVH
`define ACCUM_CONSTS_SVH

// Half-precision format
`define FP_EXP_W 5     // Biased exponent bits
`define FP_MAN_W 10    // Stored mantissa bits
`define FP_GUARD_W 3   // Guard, round, sticky below the mantissa

// Accumulation run
`define ACC_COUNT 8    // Elements per run
`define ACC_ADDR_W 3   // Element memory address bits

`define ADD_LATENCY 4  // Adder pipeline stages

`endif

/* source/fp16_pkg.sv */
`include "accum_consts.svh"

package fp16_pkg;

	// IEEE 754 half-precision word
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] expo;  // Biased by 15
		logic [`FP_MAN_W-1:0] man;
	} fp16_t;

	// Align -> mantissa add
	typedef struct packed {
		logic vld;
		logic sign;                                  // Sign of the larger operand
		logic effSub;                                // Operand signs differ
		logic [`FP_EXP_W-1:0] expo;                  // Common exponent
		logic [`FP_MAN_W:0] manMax;                  // Hidden bit included
		logic [`FP_MAN_W+`FP_GUARD_W:0] manMin;      // Shifted, GRS at the bottom
	} alignOut_t;

	// Mantissa add -> normalize
	typedef struct packed {
		logic vld;
		logic sign;
		logic effSub;
		logic [`FP_EXP_W-1:0] expo;
		logic [`FP_MAN_W+`FP_GUARD_W+1:0] sum;       // MSB is the carry
	} sumOut_t;

	// Normalize -> round
	typedef struct packed {
		logic vld;
		logic sign;
		logic effSub;
		logic zero;                                  // All-zero sum
		logic [`FP_EXP_W-1:0] expo;
		logic [`FP_MAN_W-1:0] man;
		logic guard;
		logic rnd;
		logic sticky;
	} normOut_t;

endpackage

/* source/accum_pkg.sv */
package accum_pkg;

	// Sequencer states
	typedef enum logic [1:0] {
		Idle,   // Waiting for ap_start
		Fetch,  // Memory read or finish
		Issue,  // Element on memData, launch the add
		Wait    // Add in flight
	} accumState_t;

endpackage

/* source/fpAlignStage.sv */
`timescale 1ns/1ps
`include "accum_consts.svh"

// Stage 1 of the adder: order by magnitude, align the smaller mantissa
module fpAlignStage (
	input  logic ap_clk,
	input  logic ap_rst,
	input  logic inVld,
	input  fp16_pkg::fp16_t a,
	input  fp16_pkg::fp16_t b,
	output fp16_pkg::alignOut_t out
);
	localparam int AlignW = `FP_MAN_W + 1 + `FP_GUARD_W;  // Hidden + mantissa + GRS

	fp16_pkg::fp16_t opMax;
	fp16_pkg::fp16_t opMin;
	logic bLarger;
	logic [`FP_EXP_W-1:0] shAmt;
	logic [AlignW-1:0] minExt;
	logic [AlignW-1:0] lostMask;
	logic [AlignW-1:0] minShift;
	logic sticky;
	fp16_pkg::alignOut_t nxt;

	assign bLarger = {a.expo, a.man} < {b.expo, b.man};  // Magnitude compare, sign ignored
	assign opMax = bLarger ? b : a;
	assign opMin = bLarger ? a : b;
	assign shAmt = opMax.expo - opMin.expo;  // Never negative

	// Implied one on everything except an exact zero
	assign minExt = {|{opMin.expo, opMin.man}, opMin.man, {`FP_GUARD_W{1'b0}}};
	assign minShift = minExt >> shAmt;  // Zero once shAmt reaches AlignW
	assign lostMask = ~({AlignW{1'b1}} << shAmt);
	assign sticky = |(minExt & lostMask);  // Bits shifted out

	always_comb begin
		nxt.vld = inVld;
		nxt.sign = opMax.sign;
		nxt.effSub = a.sign ^ b.sign;
		nxt.expo = opMax.expo;
		nxt.manMax = {|{opMax.expo, opMax.man}, opMax.man};
		nxt.manMin = {minShift[AlignW-1:1], minShift[0] | sticky};  // Sticky folded into LSB
	end

	always_ff @(posedge ap_clk) begin
		out <= nxt;
		if (ap_rst) begin
			out.vld <= 1'b0;  // Only the valid bit is control
		end
	end

endmodule

/* source/fpMantAddStage.sv */
`timescale 1ns/1ps
`include "accum_consts.svh"

// Stage 2 of the adder: mantissa add or subtract
module fpMantAddStage (
	input  logic ap_clk,
	input  logic ap_rst,
	input  fp16_pkg::alignOut_t in,
	output fp16_pkg::sumOut_t out
);
	localparam int SumW = `FP_MAN_W + `FP_GUARD_W + 2;  // Carry + hidden + mantissa + GRS

	logic [SumW-1:0] maxExt;
	logic [SumW-1:0] minExt;
	logic [SumW-1:0] sumRaw;
	fp16_pkg::sumOut_t nxt;

	assign maxExt = {1'b0, in.manMax, {`FP_GUARD_W{1'b0}}};
	assign minExt = {1'b0, in.manMin};
	// Larger minus smaller, so a subtract never goes negative
	assign sumRaw = in.effSub ? (maxExt - minExt) : (maxExt + minExt);

	always_comb begin
		nxt.vld = in.vld;
		nxt.sign = in.sign;
		nxt.effSub = in.effSub;
		nxt.expo = in.expo;
		nxt.sum = sumRaw;
	end

	always_ff @(posedge ap_clk) begin
		out <= nxt;
		if (ap_rst) begin
			out.vld <= 1'b0;
		end
	end

endmodule

/* source/fpNormalizeStage.sv */
`timescale 1ns/1ps
`include "accum_consts.svh"

// Stage 3 of the adder: leading one, shift, exponent fix, GRS extract
module fpNormalizeStage (
	input  logic ap_clk,
	input  logic ap_rst,
	input  fp16_pkg::sumOut_t in,
	output fp16_pkg::normOut_t out
);
	localparam int SumW = `FP_MAN_W + `FP_GUARD_W + 2;
	localparam int TopBit = SumW - 2;  // Hidden-bit position without carry
	localparam int LzW = $clog2(SumW);
	localparam int G = `FP_GUARD_W;

	logic carry;
	logic [LzW-1:0] lz;
	logic [SumW-2:0] shifted;
	fp16_pkg::normOut_t nxt;

	assign carry = in.sum[SumW-1];

	// Highest set bit below the carry; later iterations win
	always_comb begin
		lz = '0;
		for (int i = 0; i <= TopBit; i++) begin
			if (in.sum[i]) begin
				lz = LzW'(TopBit - i);
			end
		end
	end

	assign shifted = in.sum[SumW-2:0] << lz;

	always_comb begin
		nxt.vld = in.vld;
		nxt.sign = in.sign;
		nxt.effSub = in.effSub;
		nxt.zero = ~|in.sum;
		if (carry) begin  // Right by one, exponent up
			nxt.expo = in.expo + `FP_EXP_W'(1);
			nxt.man = in.sum[SumW-2 -: `FP_MAN_W];
			nxt.guard = in.sum[G];
			nxt.rnd = in.sum[G-1];
			nxt.sticky = |in.sum[G-2:0];
		end else begin  // Left by the leading-zero count
			nxt.expo = in.expo - `FP_EXP_W'(lz);
			nxt.man = shifted[SumW-3 -: `FP_MAN_W];
			nxt.guard = shifted[G-1];
			nxt.rnd = shifted[G-2];
			nxt.sticky = |shifted[G-3:0];
		end
	end

	always_ff @(posedge ap_clk) begin
		out <= nxt;
		if (ap_rst) begin
			out.vld <= 1'b0;
		end
	end

endmodule

/* source/fpRoundStage.sv */
`timescale 1ns/1ps
`include "accum_consts.svh"

// Stage 4 of the adder: round to nearest even, pack
module fpRoundStage (
	input  logic ap_clk,
	input  logic ap_rst,
	input  fp16_pkg::normOut_t in,
	output logic outVld,
	output fp16_pkg::fp16_t out
);
	logic roundUp;
	logic [`FP_MAN_W:0] manInc;  // Extra bit catches mantissa overflow
	fp16_pkg::fp16_t nxt;

	// Above half, or exactly half with an odd LSB
	assign roundUp = in.guard & (in.rnd | in.sticky | in.man[0]);
	assign manInc = {1'b0, in.man} + 1'b1;

	always_comb begin
		nxt.sign = in.sign;
		nxt.expo = in.expo;
		nxt.man = in.man;
		if (in.zero) begin
			// -0 only for two negative operands, any cancellation gives +0
			nxt.sign = in.sign & ~in.effSub;
			nxt.expo = '0;
			nxt.man = '0;
		end else if (roundUp) begin
			nxt.man = manInc[`FP_MAN_W-1:0];  // Wraps to zero on overflow
			nxt.expo = in.expo + `FP_EXP_W'(manInc[`FP_MAN_W]);
		end
	end

	always_ff @(posedge ap_clk) begin
		out <= nxt;
		if (ap_rst) begin
			outVld <= 1'b0;
		end else begin
			outVld <= in.vld;
		end
	end

endmodule

/* source/fp16AddPipe.sv */
`timescale 1ns/1ps
`include "accum_consts.svh"

// Four-stage half-precision adder, no stall
module fp16AddPipe (
	input  logic ap_clk,
	input  logic ap_rst,
	input  logic inVld,
	input  fp16_pkg::fp16_t a,
	input  fp16_pkg::fp16_t b,
	output logic outVld,
	output fp16_pkg::fp16_t res
);
	fp16_pkg::alignOut_t alignQ;  // Stage 1 regs
	fp16_pkg::sumOut_t sumQ;      // Stage 2 regs
	fp16_pkg::normOut_t normQ;    // Stage 3 regs

	fpAlignStage align (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.inVld  (inVld),
		.a      (a),
		.b      (b),
		.out    (alignQ)
	);

	fpMantAddStage mantAdd (.ap_clk(ap_clk), .ap_rst(ap_rst), .in(alignQ), .out(sumQ));

	fpNormalizeStage normalize (.ap_clk(ap_clk), .ap_rst(ap_rst), .in(sumQ), .out(normQ));

	fpRoundStage round (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.in     (normQ),
		.outVld (outVld),
		.out    (res)
	);

	// Valid travels through all four stages with fixed delay
	latencyCheck: assert property (@(posedge ap_clk) disable iff (ap_rst)
		outVld == $past(inVld, `ADD_LATENCY));

endmodule

/* source/accumSequencer.sv */
`timescale 1ns/1ps
`include "accum_consts.svh"

// Start/done control, address counter and running sum
module accumSequencer (
	input  logic ap_clk,
	input  logic ap_rst,
	input  logic ap_start,
	input  logic ap_continue,
	output logic ap_done,
	output logic ap_idle,
	output logic ap_ready,
	output logic [`ACC_ADDR_W-1:0] memAddr,
	output logic memCe,
	input  fp16_pkg::fp16_t memData,
	output logic addVld,
	output fp16_pkg::fp16_t addA,
	output fp16_pkg::fp16_t addB,
	input  logic resVld,
	input  fp16_pkg::fp16_t res,
	output fp16_pkg::fp16_t sumOut,
	output logic sumVld
);
	localparam logic [`ACC_ADDR_W:0] LastIdx = (`ACC_ADDR_W+1)'(`ACC_COUNT);

	accum_pkg::accumState_t state;
	accum_pkg::accumState_t stateNxt;
	logic [`ACC_ADDR_W:0] idx;  // One bit wider to reach ACC_COUNT
	logic doneReg;              // Done pending until ap_continue
	logic startOk;
	logic lastIdx;
	logic finish;
	fp16_pkg::fp16_t sumQ;      // Running sum
	fp16_pkg::fp16_t sumHold;   // Last result between runs

	assign startOk = (state == accum_pkg::Idle) && ap_start && !doneReg;
	assign lastIdx = (idx == LastIdx);
	assign finish = (state == accum_pkg::Fetch) && lastIdx;

	always_comb begin
		stateNxt = state;
		unique case (state)
			accum_pkg::Idle:  if (startOk) stateNxt = accum_pkg::Fetch;
			accum_pkg::Fetch: stateNxt = lastIdx ? accum_pkg::Idle : accum_pkg::Issue;
			accum_pkg::Issue: stateNxt = accum_pkg::Wait;  // Element arrives here
			accum_pkg::Wait:  if (resVld) stateNxt = accum_pkg::Fetch;
			default:          stateNxt = accum_pkg::Idle;
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= accum_pkg::Idle;
			idx <= '0;
			sumQ <= '0;  // +0
		end else begin
			state <= stateNxt;
			if (startOk) begin
				idx <= '0;
				sumQ <= '0;
			end else if (state == accum_pkg::Wait && resVld) begin
				idx <= idx + 1'b1;
				sumQ <= res;
			end
		end
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			doneReg <= 1'b0;
			sumHold <= '0;
		end else begin
			if (ap_continue) begin  // Continue wins over a new finish
				doneReg <= 1'b0;
			end else if (finish) begin
				doneReg <= 1'b1;
			end
			if (finish) begin
				sumHold <= sumQ;
			end
		end
	end

	assign memCe = (state == accum_pkg::Fetch) && !lastIdx;
	assign memAddr = idx[`ACC_ADDR_W-1:0];
	assign addVld = (state == accum_pkg::Issue);
	assign addA = sumQ;
	assign addB = memData;  // Read data is valid in Issue
	assign ap_ready = finish;
	assign sumVld = finish;
	assign ap_done = finish || doneReg;
	assign ap_idle = (state == accum_pkg::Idle) && !ap_start;
	assign sumOut = finish ? sumQ : sumHold;

	memCeInRange: assert property (@(posedge ap_clk) disable iff (ap_rst)
		memCe |-> idx < LastIdx);
	// Adder result only lands while the sequencer waits for it
	resInWait: assert property (@(posedge ap_clk) disable iff (ap_rst)
		resVld |-> state == accum_pkg::Wait);
	doneHeld: assert property (@(posedge ap_clk) disable iff (ap_rst)
		ap_done && !ap_continue |=> ap_done);

endmodule

/* source/accumTop.sv */
`timescale 1ns/1ps
`include "accum_consts.svh"

// Half-precision accumulator: sequencer plus adder pipeline
module accumTop (
	input  logic ap_clk,
	input  logic ap_rst,
	input  logic ap_start,
	output logic ap_done,
	output logic ap_idle,
	output logic ap_ready,
	input  logic ap_continue,
	output logic [`ACC_ADDR_W-1:0] memAddr,
	output logic memCe,
	input  fp16_pkg::fp16_t memData,
	output fp16_pkg::fp16_t sumOut,
	output logic sumVld
);
	logic addVld;
	logic resVld;
	fp16_pkg::fp16_t addA;  // Running sum
	fp16_pkg::fp16_t addB;  // Memory element
	fp16_pkg::fp16_t res;

	accumSequencer sequencer (
		.ap_clk, .ap_rst, .ap_start, .ap_continue, .ap_done, .ap_idle, .ap_ready,
		.memAddr, .memCe, .memData, .addVld, .addA, .addB, .resVld, .res,
		.sumOut, .sumVld
	);

	fp16AddPipe adder (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst),
		.inVld  (addVld),
		.a      (addA),
		.b      (addB),
		.outVld (resVld),
		.res    (res)
	);

endmodule

/* dv/accumTb.sv */
`timescale 1ns/1ps
`include "accum_consts.svh"

module accumTb;
	localparam int NumFixed = 6;
	localparam int NumRandom = 2;
	localparam int NumRuns = NumFixed + NumRandom;
	localparam int TimeoutCycles = 200;  // Per wait, a run needs about 50
	localparam int HoldCycles = 5;       // Cycles with ap_continue low after done
	localparam int RunBits = 16 * `ACC_COUNT;

	logic ap_clk;
	logic ap_rst;
	logic ap_start;
	logic ap_continue;
	logic ap_done;
	logic ap_idle;
	logic ap_ready;
	logic [`ACC_ADDR_W-1:0] memAddr;
	logic memCe;
	fp16_pkg::fp16_t memData;
	fp16_pkg::fp16_t sumOut;
	logic sumVld;

	// Stimulus and expected sums, one row per run
	string runName [NumRuns];
	logic [15:0] runVals [NumRuns][`ACC_COUNT];
	logic [15:0] runExp [NumRuns];

	fp16_pkg::fp16_t mem [`ACC_COUNT];  // Element memory
	int readCount [`ACC_COUNT];         // Reads per address in this run
	int nextAddr;                       // Address the next read must use
	string curTest;                     // Run the memory is serving
	int errors;
	int failedTests;
	int testsRun;
	logic timedOut;

	accumTop uut (
		.ap_clk, .ap_rst, .ap_start, .ap_done, .ap_idle, .ap_ready, .ap_continue,
		.memAddr, .memCe, .memData, .sumOut, .sumVld
	);

	initial begin
		ap_clk = 1'b0;
		forever #4 ap_clk = ~ap_clk;
	end

	// Memory answers one cycle after memCe
	always @(posedge ap_clk) begin
		if (memCe) begin
			memData <= mem[memAddr];
			if (int'(memAddr) != nextAddr) begin
				$display("ERROR %s: memAddr expected %0d actual %0d",
					curTest, nextAddr, memAddr);
				errors++;
			end
			readCount[memAddr] = readCount[memAddr] + 1;
			nextAddr++;
		end
	end

	// Integer to half precision, exact for magnitudes up to 2047
	function automatic logic [15:0] intToHalf(input int n);
		int mag;
		int msb;
		logic [15:0] h;
		if (n == 0) begin
			return 16'h0000;
		end
		mag = (n < 0) ? -n : n;
		msb = 0;
		for (int i = 0; i < 11; i++) begin
			if (mag[i]) msb = i;  // Highest set bit wins
		end
		h[15] = (n < 0);
		h[14:10] = 5'(msb + 15);
		h[9:0] = 10'(mag << (10 - msb));  // Hidden one drops off the top
		return h;
	endfunction

	// Element 0 sits in the top 16 bits
	task automatic setRun(input int r, input string name, input logic [RunBits-1:0] vals,
			input logic [15:0] expected);
		runName[r] = name;
		for (int k = 0; k < `ACC_COUNT; k++) begin
			runVals[r][k] = vals[16*(`ACC_COUNT-1-k) +: 16];
		end
		runExp[r] = expected;
	endtask

	task automatic fillRandomRun(input int r, input string name);
		int val;
		int total;
		total = 0;
		runName[r] = name;
		for (int k = 0; k < `ACC_COUNT; k++) begin
			val = int'($urandom % 201) - 100;  // Partial sums stay within 800
			total += val;
			runVals[r][k] = intToHalf(val);
		end
		runExp[r] = intToHalf(total);  // Every partial sum exact, so no rounding
	endtask

	task automatic checkBit(input string test, input string sig, input logic expected,
			input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s: %s expected %b actual %b", test, sig, expected, actual);
			errors++;
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testsRun++;
		if (errors == errBefore && !timedOut) begin
			$display("Test %s: passed", name);
		end else begin
			failedTests++;
			$display("Test %s: failed", name);
		end
	endtask

	task automatic runTest(input int r);
		int cycles;
		string name;
		name = runName[r];
		curTest = name;
		for (int k = 0; k < `ACC_COUNT; k++) begin
			mem[k] = runVals[r][k];
			readCount[k] = 0;
		end
		nextAddr = 0;
		@(posedge ap_clk);
		ap_start <= 1'b1;
		cycles = 0;
		@(negedge ap_clk);
		while (!memCe && cycles < TimeoutCycles) begin  // First read means start taken
			@(negedge ap_clk);
			cycles++;
		end
		if (!memCe) begin
			$display("%s: timed out waiting for the first memory read", name);
			timedOut = 1'b1;
			return;
		end
		@(posedge ap_clk);
		ap_start <= 1'b0;
		cycles = 0;
		@(negedge ap_clk);
		while (!sumVld && cycles < TimeoutCycles) begin
			@(negedge ap_clk);
			cycles++;
		end
		if (!sumVld) begin
			$display("%s: timed out waiting for sumVld", name);
			timedOut = 1'b1;
			return;
		end
		if (sumOut !== runExp[r]) begin
			$display("ERROR %s: sumOut expected %h actual %h", name, runExp[r], sumOut);
			errors++;
		end
		checkBit(name, "ap_done", 1'b1, ap_done);
		checkBit(name, "ap_ready", 1'b1, ap_ready);
		for (int k = 0; k < `ACC_COUNT; k++) begin
			if (readCount[k] != 1) begin
				$display("ERROR %s: reads of address %0d expected 1 actual %0d",
					name, k, readCount[k]);
				errors++;
			end
		end
		// Done pending, a new start must be ignored
		@(posedge ap_clk);
		ap_start <= 1'b1;
		repeat (HoldCycles) begin
			@(negedge ap_clk);
			if (!ap_done) begin
				$display("%s: ap_done fell while ap_continue was low", name);
				errors++;
			end
			if (memCe) begin
				$display("%s: a start was accepted while done was pending", name);
				errors++;
			end
		end
		@(posedge ap_clk);
		ap_start <= 1'b0;
		ap_continue <= 1'b1;
		@(posedge ap_clk);
		ap_continue <= 1'b0;
		@(negedge ap_clk);
		if (ap_done) begin
			$display("%s: ap_done stayed high after ap_continue", name);
			errors++;
		end
	endtask

	initial begin
		int errBefore;
		ap_rst = 1'b1;
		ap_start = 1'b0;
		ap_continue = 1'b0;
		memData = '0;
		errors = 0;
		failedTests = 0;
		testsRun = 0;
		timedOut = 1'b0;
		nextAddr = 0;
		curTest = "afterReset";
		void'($urandom(45));

		setRun(0, "intSum", 128'h3C00_4000_4200_4400_4500_4600_4700_4800, 16'h5080);
		setRun(1, "mixedSign", 128'h5640_C200_4700_D240_3C00_C000_4C00_C400, 16'h5410);
		setRun(2, "cancel", 128'h4500_C500_5640_D640_4200_C200_4700_C700, 16'h0000);
		// Running sum starts at +0, and +0 plus -0 is +0
		setRun(3, "negZeros", 128'h8000_8000_8000_8000_8000_8000_8000_8000, 16'h0000);
		setRun(4, "tieEven", 128'h6800_3C00_0000_0000_0000_0000_0000_0000, 16'h6800);
		setRun(5, "tieUp", 128'h6801_3C00_0000_0000_0000_0000_0000_0000, 16'h6802);
		fillRandomRun(6, "random0");
		fillRandomRun(7, "random1");

		repeat (4) @(posedge ap_clk);
		ap_rst <= 1'b0;

		errBefore = errors;
		@(negedge ap_clk);
		checkBit("afterReset", "ap_idle", 1'b1, ap_idle);
		checkBit("afterReset", "ap_done", 1'b0, ap_done);
		checkBit("afterReset", "ap_ready", 1'b0, ap_ready);
		checkBit("afterReset", "memCe", 1'b0, memCe);
		checkBit("afterReset", "sumVld", 1'b0, sumVld);
		reportTest("afterReset", errBefore);

		for (int r = 0; r < NumRuns; r++) begin
			errBefore = errors;
			runTest(r);
			reportTest(runName[r], errBefore);
			if (timedOut) break;
		end

		$display("Tests run %0d, tests failed %0d, errors %0d", testsRun, failedTests, errors);
		if (errors == 0 && !timedOut) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+include
source/fp16_pkg.sv
source/accum_pkg.sv
source/fpAlignStage.sv
source/fpMantAddStage.sv
source/fpNormalizeStage.sv
source/fpRoundStage.sv
source/fp16AddPipe.sv
source/accumSequencer.sv
source/accumTop.sv
dv/accumTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= accumTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert
PASS_MSG ?= Finished with no errors

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
